//--- Bender.yml
package:
  name: cpu_frontend

sources:
  - src/cpu_pkg.sv
  - src/cpu_fetch_ctrl.sv
  - src/cpu_credit_counter.sv
  - src/cpu_if.sv
  - src/cpu_imem.sv
  - src/cpu_id.sv
  - src/cpu_frontend.sv
  - target: test
    files:
      - testbench/tb_cpu_frontend.sv

//--- program.hex
// 64 instruction words, eight per line, in address order from byte 0x00
// word 60 at 0xf0 is a jal, which this decoder does not accept
00500093 00a00113 002081b3 40208233 0000a283 0040a303 ffc10393 0070f433
00316493 00412503 fff00593 00b56633 0042c693 0080a703 00e6f7b3 01c12803
01088933 7ff00993 01498a33 00892a83 00100b13 01690bb3 ffcb2c03 418b8cb3
00321d13 00ad5d93 40ddde13 01cd7eb3 00052f03 123f0f93 01ff8033 80000113
00410193 003101b3 0001a203 00520293 005282b3 00229313 0082a383 00734433
fff44493 00949533 00052583 00b58633 01862683 06468713 00e70733 00c6e7b3
00478813 01080833 0007a883 00f8e933 7ff90993 01398a33 fe0a2a83 415a8b33
00ab0b93 017b8c33 004b8c83 00000013 0000006f 00100093 0000a103 002081b3

//--- src.f
src/cpu_pkg.sv
src/cpu_fetch_ctrl.sv
src/cpu_credit_counter.sv
src/cpu_if.sv
src/cpu_imem.sv
src/cpu_id.sv
src/cpu_frontend.sv
testbench/tb_cpu_frontend.sv

//--- src/cpu_credit_counter.sv
`timescale 1ns/100ps

module cpu_credit_counter
    import cpu_pkg::*;
(
    input  logic clk_i,
    input  logic reset_i,
    input  logic take_i,   // fetch issued, one slot used
    input  logic give_i,   // consumer freed a slot
    input  logic refund_i, // squashed fetch hands its slot back
    output logic avail_o   // count nonzero
);

    logic [CREDIT_W-1:0] count_r; // free downstream slots

    // single update covers take, give and refund in the same cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            count_r <= CREDIT_W'(CREDITS); // full grant after reset
        end else begin
            count_r <= count_r + CREDIT_W'(give_i) + CREDIT_W'(refund_i)
                       - CREDIT_W'(take_i);
        end
    end

    // issue is gated on this, so the count never wraps below zero
    always_comb begin
        avail_o = (count_r != '0);
    end

endmodule

//--- src/cpu_fetch_ctrl.sv
`timescale 1ns/100ps

module cpu_fetch_ctrl
    import cpu_pkg::*;
(
    input  logic clk_i,
    input  logic reset_i,
    input  logic halt_i,         // level, stops issue while high
    input  logic jmp_valid_i,    // redirect pulse from a later stage
    input  logic illegal_i,      // decode delivered an illegal word
    input  logic credit_avail_i, // at least one downstream slot free
    output logic issue_o         // start a fetch this cycle
);

    fetch_state_e state_r;
    fetch_state_e state_d;

    // next state
    always_comb begin
        state_d = state_r;
        case (state_r)
            ST_RESET: state_d = ST_RUN; // one cycle after reset
            ST_RUN: begin
                if (jmp_valid_i) begin
                    state_d = ST_RUN;   // redirect wins over a trap
                end else if (illegal_i) begin
                    state_d = ST_TRAP;
                end else if (halt_i) begin
                    state_d = ST_HALT;
                end
            end
            ST_HALT: begin
                // an in-flight item may still turn out illegal while draining
                if (illegal_i && !jmp_valid_i) begin
                    state_d = ST_TRAP;
                end else if (!halt_i) begin
                    state_d = ST_RUN;
                end
            end
            ST_TRAP: begin
                if (jmp_valid_i) begin
                    state_d = ST_RUN; // only a redirect leaves the trap
                end
            end
            default: state_d = ST_RESET;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            state_r <= ST_RESET;
        end else begin
            state_r <= state_d;
        end
    end

    // issue only when running and nothing blocks it
    // illegal_i also blocks so at most one item trails the bad word
    always_comb begin
        issue_o = (state_r == ST_RUN) && credit_avail_i && !halt_i
                  && !jmp_valid_i && !illegal_i;
    end

endmodule

//--- src/cpu_frontend.sv
`timescale 1ns/100ps

module cpu_frontend
    import cpu_pkg::*;
(
    input  logic  clk_i,
    input  logic  reset_i,
    input  logic  halt_i,          // level
    input  logic  jmp_valid_i,     // single cycle redirect
    input  word_t jmp_addr_i,      // redirect target
    input  logic  credit_return_i, // one pulse per freed slot
    output dec_t  dec_o            // one instruction per valid cycle
);

    logic   issue;        // controller starts a fetch
    logic   credit_avail; // counter nonzero
    logic   squash;       // redirect killed the in-flight item
    logic   illegal;      // decode saw a bad opcode
    word_t  imem_addr;
    word_t  imem_data;
    fetch_t fetch;

    cpu_fetch_ctrl cpu_fetch_ctrl_inst (
        .clk_i          (clk_i),
        .reset_i        (reset_i),
        .halt_i         (halt_i),
        .jmp_valid_i    (jmp_valid_i),
        .illegal_i      (illegal),
        .credit_avail_i (credit_avail),
        .issue_o        (issue)
    );

    // squashed fetches refund in the same cycle
    cpu_credit_counter cpu_credit_counter_inst (
        .clk_i    (clk_i),
        .reset_i  (reset_i),
        .take_i   (issue),
        .give_i   (credit_return_i),
        .refund_i (squash),
        .avail_o  (credit_avail)
    );

    cpu_if cpu_if_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .issue_i     (issue),
        .jmp_valid_i (jmp_valid_i),
        .jmp_addr_i  (jmp_addr_i),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .fetch_o     (fetch),
        .squash_o    (squash)
    );

    cpu_imem cpu_imem_inst (
        .clk_i  (clk_i),
        .addr_i (imem_addr),
        .data_o (imem_data)
    );

    cpu_id cpu_id_inst (
        .clk_i       (clk_i),
        .reset_i     (reset_i),
        .jmp_valid_i (jmp_valid_i),
        .fetch_i     (fetch),
        .dec_o       (dec_o),
        .illegal_o   (illegal)
    );

endmodule

//--- src/cpu_id.sv
`timescale 1ns/100ps

module cpu_id
    import cpu_pkg::*;
(
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   jmp_valid_i, // redirect drops the item now in decode
    input  fetch_t fetch_i,     // word and pc from fetch
    output dec_t   dec_o,       // registered decode result
    output logic   illegal_o    // delivered beat is illegal
);

    instr_u ir;    // one word, two views
    dec_t   dec_d; // combinational decode
    dec_t   dec_r;

    always_comb begin
        ir = fetch_i.ir;
    end

    always_comb begin
        // fields common to both formats
        dec_d.valid    = fetch_i.valid;
        dec_d.pc       = fetch_i.pc;
        dec_d.opcode   = ir.r.opcode;
        dec_d.rd       = ir.r.rd;
        dec_d.rs1      = ir.r.rs1;
        dec_d.funct3   = ir.r.funct3;
        dec_d.rs2      = '0;
        dec_d.funct7   = '0;
        dec_d.imm      = '0;
        dec_d.is_rtype = 1'b0;
        dec_d.illegal  = 1'b0;

        case (ir.r.opcode)
            OPC_OP: begin
                // register form, no immediate
                dec_d.rs2      = ir.r.rs2;
                dec_d.funct7   = ir.r.funct7;
                dec_d.is_rtype = 1'b1;
            end
            OPC_OP_IMM, OPC_LOAD: begin
                dec_d.imm = {{(XLEN-12){ir.i.imm12[11]}}, ir.i.imm12}; // sign extend
            end
            default: begin
                dec_d.illegal = 1'b1; // anything else stops fetch
            end
        endcase
    end

    // payload every cycle, valid under reset and redirect
    always_ff @(posedge clk_i) begin
        dec_r.pc       <= dec_d.pc;
        dec_r.opcode   <= dec_d.opcode;
        dec_r.rd       <= dec_d.rd;
        dec_r.rs1      <= dec_d.rs1;
        dec_r.rs2      <= dec_d.rs2;
        dec_r.funct3   <= dec_d.funct3;
        dec_r.funct7   <= dec_d.funct7;
        dec_r.imm      <= dec_d.imm;
        dec_r.is_rtype <= dec_d.is_rtype;
        dec_r.illegal  <= dec_d.illegal;
        if (reset_i || jmp_valid_i) begin
            dec_r.valid <= 1'b0; // squashed item never leaves
        end else begin
            dec_r.valid <= dec_d.valid;
        end
    end

    always_comb begin
        dec_o     = dec_r;
        illegal_o = dec_r.valid && dec_r.illegal; // back to the controller
    end

endmodule

//--- src/cpu_if.sv
`timescale 1ns/100ps

module cpu_if
    import cpu_pkg::*;
(
    input  logic   clk_i,
    input  logic   reset_i,
    input  logic   issue_i,     // fetch the current pc this cycle
    input  logic   jmp_valid_i, // redirect pulse
    input  word_t  jmp_addr_i,  // redirect target
    output word_t  imem_addr_o, // address into the rom
    input  word_t  imem_data_i, // rom word, one cycle after the address
    output fetch_t fetch_o,     // item handed to decode
    output logic   squash_o     // redirect killed a valid item
);

    word_t pc_r;       // address of the next fetch
    word_t pc_d;
    logic  valid_r;    // item in flight with the rom
    word_t fetch_pc_r; // pc that goes with the rom word

    // next pc, priority order
    always_comb begin
        if (reset_i) begin
            pc_d = '0;
        end else if (jmp_valid_i) begin
            pc_d = jmp_addr_i;  // follow the redirect
        end else if (issue_i) begin
            pc_d = pc_r + 32'd4; // sequential step
        end else begin
            pc_d = pc_r;        // halt, trap or no credit
        end
    end

    always_ff @(posedge clk_i) begin
        pc_r <= pc_d;
    end

    // the rom samples the pc being fetched
    always_comb begin
        imem_addr_o = pc_r;
    end

    // valid lines up with the word that arrives next cycle
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            valid_r <= 1'b0;
        end else begin
            valid_r <= issue_i && !jmp_valid_i; // redirect drops the slot
        end
    end

    always_ff @(posedge clk_i) begin
        fetch_pc_r <= issue_i ? pc_r : NOP_PC; // empty slot marker
    end

    // in-flight item dies in the redirect cycle, its credit comes back
    always_comb begin
        squash_o = jmp_valid_i && valid_r;
    end

    // rom word goes straight through, nop when the slot is empty
    always_comb begin
        fetch_o.valid = valid_r;
        fetch_o.pc    = fetch_pc_r;
        fetch_o.ir    = valid_r ? imem_data_i : NOP_IR;
    end

endmodule

//--- src/cpu_imem.sv
`timescale 1ns/100ps

module cpu_imem
    import cpu_pkg::*;
(
    input  logic  clk_i,
    input  word_t addr_i, // byte address, wraps at 256 bytes
    output word_t data_o  // word one cycle after the address
);

    word_t rom [IMEM_WORDS]; // program image

    initial begin
        $readmemh("program.hex", rom);
    end

    // word index from byte address bits 7:2
    always_ff @(posedge clk_i) begin
        data_o <= rom[addr_i[IMEM_AW+1:2]];
    end

endmodule

//--- src/cpu_pkg.sv
package cpu_pkg;

    localparam int unsigned XLEN = 32;          // word width
    localparam int unsigned IMEM_WORDS = 64;    // rom depth, 256 bytes
    localparam int unsigned IMEM_AW = $clog2(IMEM_WORDS); // word index bits
    localparam int unsigned CREDITS = 4;        // slots granted after reset
    localparam int unsigned CREDIT_W = $clog2(CREDITS + 1); // holds 0..CREDITS

    typedef logic [XLEN-1:0] word_t;

    // opcodes accepted by decode
    localparam logic [6:0] OPC_OP     = 7'b0110011; // r-type alu
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011; // i-type alu
    localparam logic [6:0] OPC_LOAD   = 7'b0000011; // loads

    localparam word_t NOP_IR = 32'h0000_0013; // addi x0,x0,0
    localparam word_t NOP_PC = '1;            // marks an empty slot

    // register-register layout
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_fmt_t;

    // immediate layout
    typedef struct packed {
        logic [11:0] imm12;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    // same 32 bits, read through either format
    typedef union packed {
        word_t  raw;
        r_fmt_t r;
        i_fmt_t i;
    } instr_u;

    // one fetched item, fetch -> decode
    typedef struct packed {
        logic  valid;
        word_t pc;
        word_t ir;
    } fetch_t;

    // one decoded instruction, decode -> consumer
    typedef struct packed {
        logic       valid;
        word_t      pc;
        logic [6:0] opcode;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        logic [2:0] funct3;
        logic [6:0] funct7;
        word_t      imm;      // sign extended
        logic       is_rtype;
        logic       illegal;
    } dec_t;

    typedef enum logic [1:0] {
        ST_RESET,
        ST_RUN,
        ST_HALT,
        ST_TRAP
    } fetch_state_e;

endpackage

//--- testbench/tb_cpu_frontend.sv
`timescale 1ns/100ps

module tb_cpu_frontend
    import cpu_pkg::*;
();

    localparam int CLK_NS = 10;
    localparam int RUN_CYCLES = 250; // rough length of all tests together

    logic  clk_i = 1'b0;
    logic  reset_i;
    logic  halt_i;
    logic  jmp_valid_i;
    word_t jmp_addr_i;
    logic  credit_return_i;
    dec_t  dec_o;

    word_t prog [IMEM_WORDS]; // copy of the rom image
    dec_t  beats [$];         // delivered instructions, oldest first
    int    stamps [$];        // cycle of each beat
    int    cyc;
    int    owed;              // beats whose slot is not yet returned
    int    granted;           // credits handed out since reset
    int    delivered;
    int    extra;             // returns allowed while holding
    int    gap_left;
    bit    hold;              // consumer keeps its slots
    bit    rand_gap;          // random pause after each return
    word_t exp_pc;            // next pc the stream must show
    logic [31:0] lfsr;

    cpu_frontend cpu_frontend_inst (
        .clk_i           (clk_i),
        .reset_i         (reset_i),
        .halt_i          (halt_i),
        .jmp_valid_i     (jmp_valid_i),
        .jmp_addr_i      (jmp_addr_i),
        .credit_return_i (credit_return_i),
        .dec_o           (dec_o)
    );

    initial begin
        forever #(CLK_NS / 2) clk_i = ~clk_i;
    end

    always @(posedge clk_i) begin
        cyc <= cyc + 1;
    end

    task automatic stop_with_error(input string msg);
        $display("%s", msg);
        $display("Regression failed");
        $fatal(1);
    endtask

    task automatic compare_dec(input string name, input dec_t exp, input dec_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            stop_with_error($sformatf("Mismatch %s expected %h actual %h", name, exp, act));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_gap(output int g);
        g = 0;
        repeat (2) begin
            lfsr = lfsr_step(lfsr); // one step per bit
            g = (g << 1) | lfsr[0];
        end
    endtask

    // expected decode of the word at pc from the riscv field layout
    function automatic dec_t model_dec(input word_t pc);
        word_t ir;
        dec_t  d;
        ir = prog[pc[7:2]]; // rom wraps at 256 bytes
        d = '0;
        d.valid  = 1'b1;
        d.pc     = pc;
        d.opcode = ir[6:0];
        d.rd     = ir[11:7];
        d.funct3 = ir[14:12];
        d.rs1    = ir[19:15];
        case (ir[6:0])
            OPC_OP: begin
                d.rs2      = ir[24:20];
                d.funct7   = ir[31:25];
                d.is_rtype = 1'b1;
            end
            OPC_OP_IMM, OPC_LOAD: d.imm = {{20{ir[31]}}, ir[31:20]};
            default: d.illegal = 1'b1;
        endcase
        return d;
    endfunction

    // every valid beat sampled mid cycle
    always @(negedge clk_i) begin
        if (!reset_i && dec_o.valid) begin
            beats.push_back(dec_o);
            stamps.push_back(cyc);
            owed++;
            delivered++;
            if (delivered > granted) begin
                stop_with_error($sformatf("%0d instructions delivered on only %0d credits",
                                          delivered, granted));
            end
        end
    end

    // consumer pays back one slot per beat
    always @(posedge clk_i) begin
        if (gap_left != 0) begin
            gap_left--;
            credit_return_i <= 1'b0;
        end else if (!reset_i && owed != 0 && (!hold || extra != 0)) begin
            credit_return_i <= 1'b1;
            owed--;
            granted++;
            if (hold) begin
                extra--;
            end
            if (rand_gap) begin
                draw_gap(gap_left);
            end
        end else begin
            credit_return_i <= 1'b0;
        end
    end

    task automatic check_next(input string name);
        dec_t got;
        while (beats.size() == 0) begin
            @(posedge clk_i);
        end
        got = beats.pop_front();
        void'(stamps.pop_front());
        compare_dec(name, model_dec(exp_pc), got);
        exp_pc += 4; // sequential step
    endtask

    task automatic expect_quiet(input string name, input int cycles);
        repeat (cycles) @(posedge clk_i);
        if (beats.size() != 0) begin
            stop_with_error($sformatf("%s: unexpected instruction at pc %h", name, beats[0].pc));
        end
    endtask

    // pulse a jump then check what landed up to the jump cycle
    task automatic redirect(input string name, input word_t target, output int r,
                            output int last);
        @(posedge clk_i);
        jmp_valid_i <= 1'b1;
        jmp_addr_i  <= target;
        @(negedge clk_i);
        r = cyc;
        @(posedge clk_i);
        jmp_valid_i <= 1'b0;
        repeat (4) @(posedge clk_i);
        last = -1;
        while (stamps.size() != 0 && stamps[0] <= r) begin
            last = stamps[0];
            check_next(name);
        end
        exp_pc = target;
    endtask

    // drain under halt then hold all slots and expect CREDITS beats
    task automatic credit_window(input string name, input int releases);
        @(negedge clk_i);
        rand_gap = 1'b0;
        @(posedge clk_i);
        halt_i <= 1'b1;
        repeat (12) @(posedge clk_i);
        while (beats.size() != 0) begin
            check_next(name);
        end
        compare_word(name, 0, owed); // all slots back home
        @(negedge clk_i);
        hold = 1'b1;
        @(posedge clk_i);
        halt_i <= 1'b0;
        repeat (CREDITS) check_next(name);
        expect_quiet(name, 10);
        repeat (releases) begin
            @(negedge clk_i);
            extra = 1; // one slot back gives one more beat
            check_next(name);
            expect_quiet(name, 8);
        end
    endtask

    task automatic test_reset();
        int start;
        @(negedge clk_i);
        start = cyc; // the ST_RESET cycle
        while (beats.size() == 0) begin
            @(posedge clk_i);
        end
        compare_word("reset", start + 3, stamps[0]); // reset cycle plus 2 latency
        check_next("reset");
    endtask

    task automatic test_sequential();
        repeat (16) check_next("sequential"); // immediate returns
    endtask

    task automatic test_redirect();
        int r;
        int last;
        @(negedge clk_i);
        hold = 1'b0;
        repeat (6) check_next("redirect"); // stream back at full rate
        redirect("redirect", 32'h20, r, last);
        compare_word("redirect", r, last); // issued two cycles before still lands
        compare_word("redirect", r + 3, stamps[0]); // first target fetch issues at r+1
        repeat (6) check_next("redirect");
        credit_window("redirect", 0); // refund keeps the total at CREDITS
    endtask

    task automatic test_halt();
        @(negedge clk_i);
        hold = 1'b0;
        rand_gap = 1'b1;
        repeat (8) check_next("halt");
        @(posedge clk_i);
        halt_i <= 1'b1;
        repeat (3) @(posedge clk_i);
        while (beats.size() != 0) begin
            check_next("halt"); // in-flight items
        end
        expect_quiet("halt", 12);
        @(posedge clk_i);
        halt_i <= 1'b0;
        repeat (8) check_next("halt"); // no gap and no repeat
    endtask

    task automatic test_illegal();
        int r;
        int last;
        @(negedge clk_i);
        rand_gap = 1'b0;
        redirect("illegal", 32'he8, r, last);
        repeat (3) check_next("illegal"); // third one is the jal at 0xf0
        repeat (10) @(posedge clk_i);
        if (beats.size() > 1) begin
            stop_with_error("more than one instruction followed the illegal one");
        end
        while (beats.size() != 0) begin
            check_next("illegal");
        end
        expect_quiet("illegal", 10); // trapped
        redirect("illegal", 32'h10, r, last);
        compare_word("illegal", r + 3, stamps[0]); // trap left, target fetch at r+1
        repeat (6) check_next("illegal");
    endtask

    initial begin
        #(40 * RUN_CYCLES * CLK_NS);
        stop_with_error("watchdog expired before the tests finished");
    end

    initial begin
        reset_i = 1'b1;
        halt_i = 1'b0;
        jmp_valid_i = 1'b0;
        jmp_addr_i = '0;
        credit_return_i = 1'b0;
        cyc = 0;
        owed = 0;
        granted = CREDITS;
        delivered = 0;
        extra = 0;
        gap_left = 0;
        hold = 1'b0;
        rand_gap = 1'b0;
        exp_pc = '0;
        lfsr = 32'h20e3_0f60;
        $readmemh("program.hex", prog);
        repeat (5) @(posedge clk_i);
        reset_i <= 1'b0;
        test_reset();
        test_sequential();
        credit_window("credit_limit", 3);
        test_redirect();
        test_halt();
        test_illegal();
        $display("Regression passed");
        $finish;
    end

endmodule
